// ==== Bender.yml ====
package:
  name: aluCore

sources:
  # Package first, then the stages, then the top level
  - verilog/corePkg.sv
  - verilog/instrDecoder.sv
  - verilog/regFile.sv
  - verilog/decodeStage.sv
  - verilog/executeStage.sv
  - verilog/resultStage.sv
  - verilog/aluCore.sv

  - target: test
    files:
      - tb/aluCoreTb.sv

// ==== tb/aluCoreTb.sv ====
module aluCoreTb import corePkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TimeoutCycles = 400 * 8 + 100;
    // Supported function codes and opcodes, picked by index
    localparam logic [71:0] RFunctList = {FnAdd, FnAddu, FnSub, FnSubu, FnAnd, FnOr,
                                          FnXor, FnNor, FnSlt, FnSll, FnSrl, FnSra};
    localparam logic [41:0] IOpList = {OpAddi, OpAddiu, OpSlti, OpAndi, OpOri, OpXori, OpLui};

    logic     clk;
    logic     rst;
    instrWord instr;
    logic     instrValid;
    logic     instrReady;
    regAddr   wbReg;
    dataWord  wbData;
    logic     wbValid;
    logic     wbReady;

    logic [31:0] lfsrReg;
    logic        readyPhase;
    logic        instrSupported;
    int          issued;
    int          acceptedCount;
    int          cycleCount;
    int          valueErrors;
    int          protocolErrors;
    dataWord     refRegs [0:31];
    regAddr      expRegQ [$];
    dataWord     expDataQ [$];
    regAddr      modelDest;
    dataWord     modelValue;

    aluCore dut0 (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .wbReg      (wbReg),
        .wbData     (wbData),
        .wbValid    (wbValid),
        .wbReady    (wbReady)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic takeBit();
        logic fb;
        fb = lfsrReg[31] ^ lfsrReg[21] ^ lfsrReg[1] ^ lfsrReg[0];
        lfsrReg = {lfsrReg[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], takeBit()};
        end
        return value;
    endfunction

    // Expected result from the MIPS rules, returns 0 for unsupported words
    function automatic logic refExecute(input instrWord w, output regAddr dest,
                                        output dataWord value);
        dataWord a;
        dataWord b;
        dataWord immS;
        dataWord immZ;
        a = refRegs[w[25:21]];
        b = refRegs[w[20:16]];
        immS = {{16{w[15]}}, w[15:0]};
        immZ = {16'h0000, w[15:0]};
        dest = w[20:16];
        value = '0;
        case (w[31:26])
            OpRType: begin
                dest = w[15:11];
                case (w[5:0])
                    FnAdd, FnAddu: value = a + b;
                    FnSub, FnSubu: value = a - b;
                    FnAnd:         value = a & b;
                    FnOr:          value = a | b;
                    FnXor:         value = a ^ b;
                    FnNor:         value = ~(a | b);
                    FnSlt:         value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FnSll:         value = b << w[10:6];
                    FnSrl:         value = b >> w[10:6];
                    FnSra:         value = $signed(b) >>> w[10:6];
                    default:       return 1'b0;
                endcase
            end
            OpAddi, OpAddiu: value = a + immS;
            OpSlti:          value = ($signed(a) < $signed(immS)) ? 32'd1 : 32'd0;
            OpAndi:          value = a & immZ;
            OpOri:           value = a | immZ;
            OpXori:          value = a ^ immZ;
            OpLui:           value = {w[15:0], 16'h0000};
            default:         return 1'b0;
        endcase
        return 1'b1;
    endfunction

    function automatic logic isSupported(input instrWord w);
        regAddr unusedDest;
        dataWord unusedValue;
        return refExecute(w, unusedDest, unusedValue);
    endfunction

    // Registers limited to 0..7 so dependencies are frequent
    function automatic instrWord makeInstr();
        instrWord w;
        regAddr rs;
        regAddr rt;
        regAddr rd;
        shiftAmt sh;
        logic [15:0] imm;
        int pick;
        rs = regAddr'(takeBits(3));
        rt = regAddr'(takeBits(3));
        rd = regAddr'(takeBits(3));
        sh = shiftAmt'(takeBits(5));
        imm = 16'(takeBits(16));
        if (takeBits(4) == 0) begin
            // SLTU and LW are outside the kept set
            if (takeBit())
                w = {OpRType, rs, rt, rd, sh, 6'h2B};
            else
                w = {6'h23, rs, rt, imm};
        end else begin
            pick = int'(takeBits(5)) % 19;
            if (pick < 12)
                w = {OpRType, rs, rt, rd, sh, RFunctList[pick*6 +: 6]};
            else
                w = {IOpList[(pick-12)*6 +: 6], rs, rt, imm};
        end
        return w;
    endfunction

    // Write-back check first, then the model takes the new input
    always @(posedge clk) begin
        if (!rst) begin
            if (wbValid && wbReady) begin
                if (expRegQ.size() == 0) begin
                    protocolErrors++;
                    $display("%0t: write-back to register %0d with nothing outstanding",
                             $time, wbReg);
                end else begin
                    wbRegCheck: assert (wbReg == expRegQ[0]) else begin
                        valueErrors++;
                        $display("[FAIL] %0t wbReg expected %0d got %0d",
                                 $time, expRegQ[0], wbReg);
                    end
                    wbDataCheck: assert (wbData == expDataQ[0]) else begin
                        valueErrors++;
                        $display("[FAIL] %0t wbData expected %08h got %08h",
                                 $time, expDataQ[0], wbData);
                    end
                    void'(expRegQ.pop_front());
                    void'(expDataQ.pop_front());
                end
            end
            if (instrValid && instrReady) begin
                if (refExecute(instr, modelDest, modelValue)) begin
                    if (modelDest != '0)
                        refRegs[modelDest] = modelValue;
                    expRegQ.push_back(modelDest);
                    expDataQ.push_back(modelValue);
                end
                acceptedCount++;
            end
        end
    end

    stallHold: assert property (@(posedge clk) disable iff (rst)
        (wbValid && !wbReady) |=> (wbValid && $stable(wbReg) && $stable(wbData)))
        else begin
            protocolErrors++;
            $display("%0t: write-back output changed while stalled", $time);
        end

    fullStall: assert property (@(posedge clk) disable iff (rst)
        (wbValid && !wbReady && instrValid && instrReady) |=> (wbReady || !instrReady))
        else begin
            protocolErrors++;
            $display("%0t: input still accepted with the pipeline full", $time);
        end

    readyLatency: assert property (@(posedge clk) disable iff (rst)
        (readyPhase && instrValid && instrReady && instrSupported) |-> ##2 wbValid)
        else begin
            protocolErrors++;
            $display("%0t: result not on write-back two cycles after input", $time);
        end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout after %0d cycles with %0d write-backs outstanding",
                     cycleCount, expRegQ.size());
            $display("Errors: value %0d, protocol %0d", valueErrors, protocolErrors);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic runPhase(input int count, input logic holdReady);
        int target;
        logic pending;
        target = issued + count;
        while (acceptedCount < target) begin
            @(negedge clk);
            wbReady = holdReady ? 1'b1 : takeBit();
            pending = instrValid && acceptedCount < issued;
            if (!pending) begin
                if (issued < target && takeBits(2) != 0) begin
                    instr = makeInstr();
                    instrSupported = isSupported(instr);
                    instrValid = 1'b1;
                    issued++;
                end else begin
                    instrValid = 1'b0;
                end
            end
        end
    endtask

    // Two pipeline stages, so three idle cycles show any stray write-back
    task automatic drain();
        @(negedge clk);
        instrValid = 1'b0;
        wbReady = 1'b1;
        repeat (3) @(negedge clk);
    endtask

    initial begin
        rst = 1'b1;
        instr = '0;
        instrValid = 1'b0;
        wbReady = 1'b0;
        instrSupported = 1'b0;
        readyPhase = 1'b0;
        lfsrReg = 32'h0181ee29;
        issued = 0;
        acceptedCount = 0;
        cycleCount = 0;
        valueErrors = 0;
        protocolErrors = 0;
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Full-rate phase for the latency check
        readyPhase = 1'b1;
        runPhase(150, 1'b1);
        drain();
        readyPhase = 1'b0;

        // Random back-pressure
        runPhase(250, 1'b0);
        drain();

        endCheck: assert (expRegQ.size() == 0 && !wbValid) else begin
            protocolErrors++;
            $display("Pipeline did not drain, %0d write-backs missing", expRegQ.size());
        end
        $display("Errors: value %0d, protocol %0d", valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== verilog/aluCore.sv ====
module aluCore import corePkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  instrWord instr,
    input  logic     instrValid,
    output logic     instrReady,
    output regAddr   wbReg,
    output dataWord  wbData,
    output logic     wbValid,
    input  logic     wbReady
);

    logic    decValid;
    aluOp    decOp;
    dataWord opA;
    dataWord opB;
    dataWord decImm;
    logic    decUseImm;
    shiftAmt decShamt;
    regAddr  decDest;
    dataWord aluResult;
    logic    stageAdvance;
    logic    regWrite;
    regAddr  regWriteAddr;
    dataWord regWriteData;

    decodeStage decode0 (
        .clk          (clk),
        .rst          (rst),
        .instr        (instr),
        .instrValid   (instrValid),
        .instrReady   (instrReady),
        .stageAdvance (stageAdvance),
        .regWrite     (regWrite),
        .regWriteAddr (regWriteAddr),
        .regWriteData (regWriteData),
        .decValid     (decValid),
        .decOp        (decOp),
        .opA          (opA),
        .opB          (opB),
        .decImm       (decImm),
        .decUseImm    (decUseImm),
        .decShamt     (decShamt),
        .decDest      (decDest)
    );

    executeStage execute0 (
        .decOp     (decOp),
        .opA       (opA),
        .opB       (opB),
        .decImm    (decImm),
        .decUseImm (decUseImm),
        .decShamt  (decShamt),
        .aluResult (aluResult)
    );

    resultStage result0 (
        .clk          (clk),
        .rst          (rst),
        .decValid     (decValid),
        .decDest      (decDest),
        .aluResult    (aluResult),
        .wbReady      (wbReady),
        .wbReg        (wbReg),
        .wbData       (wbData),
        .wbValid      (wbValid),
        .stageAdvance (stageAdvance),
        .regWrite     (regWrite),
        .regWriteAddr (regWriteAddr),
        .regWriteData (regWriteData)
    );

endmodule

// ==== verilog/corePkg.sv ====
package corePkg;

    // Widths fixed by the MIPS ISA
    typedef logic [31:0] dataWord;
    typedef logic [31:0] instrWord;
    typedef logic [4:0]  regAddr;
    typedef logic [4:0]  shiftAmt;
    typedef logic [5:0]  opcodeField;
    typedef logic [5:0]  functField;

    // Primary opcodes, instr[31:26]
    localparam opcodeField OpRType = 6'h00;
    localparam opcodeField OpAddi  = 6'h08;
    localparam opcodeField OpAddiu = 6'h09;
    localparam opcodeField OpSlti  = 6'h0A;
    localparam opcodeField OpAndi  = 6'h0C;
    localparam opcodeField OpOri   = 6'h0D;
    localparam opcodeField OpXori  = 6'h0E;
    localparam opcodeField OpLui   = 6'h0F;

    // R-type function codes, instr[5:0]
    localparam functField FnSll  = 6'h00;
    localparam functField FnSrl  = 6'h02;
    localparam functField FnSra  = 6'h03;
    localparam functField FnAdd  = 6'h20;
    localparam functField FnAddu = 6'h21;
    localparam functField FnSub  = 6'h22;
    localparam functField FnSubu = 6'h23;
    localparam functField FnAnd  = 6'h24;
    localparam functField FnOr   = 6'h25;
    localparam functField FnXor  = 6'h26;
    localparam functField FnNor  = 6'h27;
    localparam functField FnSlt  = 6'h2A;

    // Operations the execute stage knows
    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluNor,
        AluSlt,
        AluSll,
        AluSrl,
        AluSra,
        AluLui
    } aluOp;

endpackage

// ==== verilog/decodeStage.sv ====
module decodeStage import corePkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  instrWord instr,
    input  logic     instrValid,
    output logic     instrReady,
    input  logic     stageAdvance,
    input  logic     regWrite,
    input  regAddr   regWriteAddr,
    input  dataWord  regWriteData,
    output logic     decValid,
    output aluOp     decOp,
    output dataWord  opA,
    output dataWord  opB,
    output dataWord  decImm,
    output logic     decUseImm,
    output shiftAmt  decShamt,
    output regAddr   decDest
);

    instrWord decInstr;
    logic     decHeld;
    logic     supported;
    logic     signExtend;
    regAddr   srcA;
    regAddr   srcB;
    dataWord  rfDataA;
    dataWord  rfDataB;

    // Free slot, or the held instruction leaves this cycle
    assign instrReady = stageAdvance || !decHeld;

    always_ff @(posedge clk) begin
        if (rst) begin
            decHeld <= 1'b0;
        end else if (instrReady) begin
            decHeld <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (instrReady && instrValid) begin
            decInstr <= instr;
        end
    end

    instrDecoder decoder0 (
        .instr      (decInstr),
        .supported  (supported),
        .op         (decOp),
        .useImm     (decUseImm),
        .signExtend (signExtend),
        .srcA       (srcA),
        .srcB       (srcB),
        .dest       (decDest)
    );

    regFile regFile0 (
        .clk       (clk),
        .rst       (rst),
        .readAddrA (srcA),
        .readAddrB (srcB),
        .readDataA (rfDataA),
        .readDataB (rfDataB),
        .writeEn   (regWrite),
        .writeAddr (regWriteAddr),
        .writeData (regWriteData)
    );

    // Register file forwards the pending write-back
    assign opA = rfDataA;
    assign opB = rfDataB;

    assign decImm = signExtend ? {{16{decInstr[15]}}, decInstr[15:0]}
                               : {16'h0000, decInstr[15:0]};
    assign decShamt = decInstr[10:6];

    // Unsupported words drain without reaching write-back
    assign decValid = decHeld && supported;

    // A write-back transfer always frees the result register
    writeAdvance: assert property (@(posedge clk) disable iff (rst)
        regWrite |-> stageAdvance);

endmodule

// ==== verilog/executeStage.sv ====
module executeStage import corePkg::*; (
    input  aluOp    decOp,
    input  dataWord opA,
    input  dataWord opB,
    input  dataWord decImm,
    input  logic    decUseImm,
    input  shiftAmt decShamt,
    output dataWord aluResult
);

    dataWord operandB;
    logic    lessThan;

    // Second operand is the immediate for I-type
    assign operandB = decUseImm ? decImm : opB;

    assign lessThan = $signed(opA) < $signed(operandB);

    always_comb begin
        case (decOp)
            // No overflow trap, results wrap
            AluAdd: begin
                aluResult = opA + operandB;
            end
            AluSub: begin
                aluResult = opA - operandB;
            end
            AluAnd: begin
                aluResult = opA & operandB;
            end
            AluOr: begin
                aluResult = opA | operandB;
            end
            AluXor: begin
                aluResult = opA ^ operandB;
            end
            AluNor: begin
                aluResult = ~(opA | operandB);
            end
            AluSlt: begin
                aluResult = {31'b0, lessThan};
            end
            // Shifts act on rt by the shamt field
            AluSll: begin
                aluResult = opB << decShamt;
            end
            AluSrl: begin
                aluResult = opB >> decShamt;
            end
            AluSra: begin
                aluResult = dataWord'($signed(opB) >>> decShamt);
            end
            AluLui: begin
                aluResult = {decImm[15:0], 16'h0000};
            end
            default: begin
                aluResult = '0;
            end
        endcase
    end

endmodule

// ==== verilog/instrDecoder.sv ====
module instrDecoder import corePkg::*; (
    input  instrWord instr,
    output logic     supported,
    output aluOp     op,
    output logic     useImm,
    output logic     signExtend,
    output regAddr   srcA,
    output regAddr   srcB,
    output regAddr   dest
);

    opcodeField opcode;
    functField  funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    // rs and rt are always the read ports
    assign srcA = instr[25:21];
    assign srcB = instr[20:16];

    always_comb begin
        supported  = 1'b0;
        op         = AluAdd;
        useImm     = 1'b0;
        signExtend = 1'b0;
        dest       = instr[15:11];

        case (opcode)
            OpRType: begin
                supported = 1'b1;
                case (funct)
                    FnAdd, FnAddu: op = AluAdd;
                    FnSub, FnSubu: op = AluSub;
                    FnAnd:         op = AluAnd;
                    FnOr:          op = AluOr;
                    FnXor:         op = AluXor;
                    FnNor:         op = AluNor;
                    FnSlt:         op = AluSlt;
                    FnSll:         op = AluSll;
                    FnSrl:         op = AluSrl;
                    FnSra:         op = AluSra;
                    default:       supported = 1'b0;
                endcase
            end
            OpAddi, OpAddiu: begin
                supported  = 1'b1;
                op         = AluAdd;
                useImm     = 1'b1;
                signExtend = 1'b1;
                dest       = instr[20:16];
            end
            OpSlti: begin
                supported  = 1'b1;
                op         = AluSlt;
                useImm     = 1'b1;
                signExtend = 1'b1;
                dest       = instr[20:16];
            end
            // Logical immediates are zero extended
            OpAndi, OpOri, OpXori: begin
                supported = 1'b1;
                useImm    = 1'b1;
                dest      = instr[20:16];
                if (opcode == OpAndi)
                    op = AluAnd;
                else if (opcode == OpOri)
                    op = AluOr;
                else
                    op = AluXor;
            end
            OpLui: begin
                supported = 1'b1;
                op        = AluLui;
                useImm    = 1'b1;
                dest      = instr[20:16];
            end
            default: supported = 1'b0;
        endcase
    end

endmodule

// ==== verilog/regFile.sv ====
module regFile import corePkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  regAddr  readAddrA,
    input  regAddr  readAddrB,
    output dataWord readDataA,
    output dataWord readDataB,
    input  logic    writeEn,
    input  regAddr  writeAddr,
    input  dataWord writeData
);

    // Register 0 has no storage
    dataWord regs [1:31];

    // Same-cycle write is visible to the reader
    function automatic dataWord readPort(input regAddr addr);
        dataWord value;
        if (addr == '0)
            value = '0;
        else if (writeEn && writeAddr == addr)
            value = writeData;
        else
            value = regs[addr];
        return value;
    endfunction

    assign readDataA = readPort(readAddrA);
    assign readDataB = readPort(readAddrB);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

// ==== verilog/resultStage.sv ====
module resultStage import corePkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    decValid,
    input  regAddr  decDest,
    input  dataWord aluResult,
    input  logic    wbReady,
    output regAddr  wbReg,
    output dataWord wbData,
    output logic    wbValid,
    output logic    stageAdvance,
    output logic    regWrite,
    output regAddr  regWriteAddr,
    output dataWord regWriteData
);

    // Register moves when empty or being drained
    assign stageAdvance = !wbValid || wbReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            wbValid <= 1'b0;
        end else if (stageAdvance) begin
            wbValid <= decValid;
        end
    end

    always_ff @(posedge clk) begin
        if (stageAdvance) begin
            wbReg  <= decDest;
            wbData <= aluResult;
        end
    end

    // Register file write happens on the write-back transfer
    assign regWrite     = wbValid && wbReady;
    assign regWriteAddr = wbReg;
    assign regWriteData = wbData;

    // Decoded instruction waits in place until this register takes it
    decodeHold: assert property (@(posedge clk) disable iff (rst)
        (decValid && !stageAdvance) |=> (decValid && $stable(decDest)));

endmodule

// ==== vlog.f ====
verilog/corePkg.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/resultStage.sv
verilog/aluCore.sv
tb/aluCoreTb.sv
